//--- src/qdiv_pkg.sv
package qdiv_pkg;

    ////////////////////////////////////////
    // widths and q format
    ////////////////////////////////////////

    localparam int DATA_WIDTH = 32;                      // operands, quotient, remainder
    localparam int FRAC_BITS = 10;                       // q22.10
    localparam int WIDE_WIDTH = DATA_WIDTH + FRAC_BITS;  // scaled numerator, also iteration count
    localparam int PART_WIDTH = DATA_WIDTH + 2;          // partial remainder with sign and carry
    localparam int COUNT_WIDTH = $clog2(WIDE_WIDTH);
    localparam int DIV_LATENCY = WIDE_WIDTH + 3;         // accepted valid_in to valid_out

    // saturation limits of the signed result
    localparam logic signed [DATA_WIDTH-1:0] DATA_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam logic signed [DATA_WIDTH-1:0] DATA_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    ////////////////////////////////////////
    // core fsm
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        core_idle,
        core_iterate,
        core_correct
    } core_state_t;

    ////////////////////////////////////////
    // datapath bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] dividend;
        logic signed [DATA_WIDTH-1:0] divisor;
    } div_request_t;

    typedef struct packed {
        logic [WIDE_WIDTH-1:0] numerator;    // |dividend| << FRAC_BITS
        logic [DATA_WIDTH-1:0] denominator;  // |divisor|
    } core_operands_t;

    typedef struct packed {
        logic quotient_negative;
        logic remainder_negative;  // follows the dividend
        logic div_by_zero;
    } prep_info_t;

    typedef struct packed {
        logic [WIDE_WIDTH-1:0] quotient;
        logic [DATA_WIDTH-1:0] remainder;
    } core_result_t;

    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] quotient;
        logic signed [DATA_WIDTH-1:0] remainder;
        logic overflow;
        logic div_by_zero;
    } div_result_t;

endpackage

//--- src/div_operand_prep.sv
`timescale 1ns/1ns

module div_operand_prep
    import qdiv_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  div_request_t   request,
    input  logic           valid_in,
    input  logic           core_busy,
    output core_operands_t operands,
    output prep_info_t     info,
    output logic           start,
    output logic           busy
);

    logic                  accept;
    logic                  dividend_neg;
    logic                  divisor_neg;
    logic [DATA_WIDTH-1:0] dividend_mag;
    logic [DATA_WIDTH-1:0] divisor_mag;

    assign busy = start | core_busy;  // covers the gap before the core wakes up
    assign accept = valid_in & ~busy;

    ////////////////////////////////////////
    // sign and magnitude split
    ////////////////////////////////////////

    always_comb begin
        dividend_neg = request.dividend[DATA_WIDTH-1];
        divisor_neg = request.divisor[DATA_WIDTH-1];
        // two's complement negate, -2^31 comes out as 2^31 unsigned
        dividend_mag = dividend_neg ? -request.dividend : request.dividend;
        divisor_mag = divisor_neg ? -request.divisor : request.divisor;
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            operands.numerator <= {dividend_mag, {FRAC_BITS{1'b0}}};
            operands.denominator <= divisor_mag;
            info.quotient_negative <= dividend_neg ^ divisor_neg;
            info.remainder_negative <= dividend_neg;
            info.div_by_zero <= (request.divisor == '0);
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            start <= 1'b0;
        end else begin
            start <= accept;  // one cycle, busy blocks a second accept
        end
    end

    // the core must have fully finished before it is kicked again
    start_while_core_busy: assert property (
        @(posedge clock) disable iff (reset)
        start |-> !core_busy
    );

endmodule

//--- src/nonrestoring_divider.sv
`timescale 1ns/1ns

module nonrestoring_divider
    import qdiv_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           start,
    input  core_operands_t operands,
    output logic           core_busy,
    output logic           done,
    output core_result_t   core_result
);

    core_state_t            state;
    logic [COUNT_WIDTH-1:0] count;
    logic [PART_WIDTH-1:0]  partial;       // msb is the sign
    logic [WIDE_WIDTH-1:0]  quot;          // numerator shifts out, quotient shifts in
    logic [DATA_WIDTH-1:0]  divisor_q;
    logic [PART_WIDTH-1:0]  divisor_ext;
    logic [PART_WIDTH-1:0]  shifted;
    logic [PART_WIDTH-1:0]  partial_next;

    assign core_busy = (state != core_idle) | done;

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= core_idle;
            count <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                core_idle: begin
                    if (start) begin
                        state <= core_iterate;
                        count <= '0;
                    end
                end
                core_iterate: begin
                    count <= count + 1'b1;
                    if (count == COUNT_WIDTH'(WIDE_WIDTH - 1)) begin
                        state <= core_correct;  // last quotient bit goes in this edge
                    end
                end
                core_correct: begin
                    state <= core_idle;
                    done <= 1'b1;
                end
                default: begin
                    state <= core_idle;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // datapath
    ////////////////////////////////////////

    always_comb begin
        divisor_ext = {2'b00, divisor_q};
        shifted = {partial[PART_WIDTH-2:0], quot[WIDE_WIDTH-1]};
        // add back when the last step went negative, otherwise subtract
        if (partial[PART_WIDTH-1]) begin
            partial_next = shifted + divisor_ext;
        end else begin
            partial_next = shifted - divisor_ext;
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            core_idle: begin
                if (start) begin
                    partial <= '0;
                    quot <= operands.numerator;
                    divisor_q <= operands.denominator;
                end
            end
            core_iterate: begin
                partial <= partial_next;
                quot <= {quot[WIDE_WIDTH-2:0], ~partial_next[PART_WIDTH-1]};
            end
            core_correct: begin
                if (partial[PART_WIDTH-1]) begin
                    partial <= partial + divisor_ext;  // final restore of the remainder
                end
            end
            default: begin
                partial <= partial;
            end
        endcase
    end

    // remainder is below the divisor here, so the low word holds all of it
    assign core_result.quotient = quot;
    assign core_result.remainder = partial[DATA_WIDTH-1:0];

    done_one_cycle: assert property (
        @(posedge clock) disable iff (reset)
        done |=> !done
    );

    start_only_in_idle: assert property (
        @(posedge clock) disable iff (reset)
        start |-> (state == core_idle)
    );

endmodule

//--- src/div_result_format.sv
`timescale 1ns/1ns

module div_result_format
    import qdiv_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         done,
    input  core_result_t core_result,
    input  prep_info_t   info,
    output div_result_t  result,
    output logic         valid_out
);

    logic signed [WIDE_WIDTH:0]   quot_wide;    // magnitude plus sign bit
    logic signed [WIDE_WIDTH:0]   quot_signed;
    logic signed [DATA_WIDTH-1:0] rem_signed;
    div_result_t                  formatted;

    ////////////////////////////////////////
    // sign restore and saturation
    ////////////////////////////////////////

    always_comb begin
        quot_wide = {1'b0, core_result.quotient};
        quot_signed = info.quotient_negative ? -quot_wide : quot_wide;
        rem_signed = info.remainder_negative ? -core_result.remainder : core_result.remainder;

        formatted.remainder = rem_signed;
        formatted.div_by_zero = 1'b0;
        formatted.overflow = 1'b0;
        formatted.quotient = quot_signed[DATA_WIDTH-1:0];

        if (info.div_by_zero) begin
            // saturate toward the dividend's sign, nothing left over
            formatted.quotient = info.remainder_negative ? DATA_MIN : DATA_MAX;
            formatted.remainder = '0;
            formatted.div_by_zero = 1'b1;
        end else if (quot_signed > DATA_MAX) begin
            formatted.quotient = DATA_MAX;
            formatted.overflow = 1'b1;
        end else if (quot_signed < DATA_MIN) begin
            formatted.quotient = DATA_MIN;
            formatted.overflow = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (done) begin
            result <= formatted;  // held until the next done
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= done;
        end
    end

    flags_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        valid_out |-> !(result.overflow && result.div_by_zero)
    );

endmodule

//--- src/fixed_point_divider.sv
`timescale 1ns/1ns

module fixed_point_divider
    import qdiv_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  div_request_t request,
    input  logic         valid_in,
    output div_result_t  result,
    output logic         valid_out,
    output logic         busy
);

    core_operands_t operands;
    prep_info_t     info;
    logic           start;
    logic           core_busy;
    logic           done;
    core_result_t   core_result;

    div_operand_prep prep_i (
        .clock     (clock),
        .reset     (reset),
        .request   (request),
        .valid_in  (valid_in),
        .core_busy (core_busy),
        .operands  (operands),
        .info      (info),
        .start     (start),
        .busy      (busy)
    );

    nonrestoring_divider core_i (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .operands    (operands),
        .core_busy   (core_busy),
        .done        (done),
        .core_result (core_result)
    );

    // info stays stable from accept through done, no need to pipe it
    div_result_format format_i (
        .clock       (clock),
        .reset       (reset),
        .done        (done),
        .core_result (core_result),
        .info        (info),
        .result      (result),
        .valid_out   (valid_out)
    );

endmodule

//--- dv/div_ref_model.svh
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

////////////////////////////////////////
// expected result of one request
////////////////////////////////////////

function automatic div_result_t ref_divide(input div_request_t req);
    longint      dividend;
    longint      divisor;
    longint      scaled;
    longint      quot;
    longint      rem;
    div_result_t res;
    dividend = longint'($signed(req.dividend));
    divisor = longint'($signed(req.divisor));
    scaled = dividend * (longint'(1) << FRAC_BITS);  // dividend in the wider q format
    res = '0;
    if (divisor == 0) begin
        res.div_by_zero = 1'b1;
        res.quotient = (dividend < 0) ? DATA_MIN : DATA_MAX;
    end else begin
        quot = scaled / divisor;        // truncates toward zero
        rem = scaled - quot * divisor;  // keeps the dividend's sign
        res.remainder = DATA_WIDTH'(rem);
        if (quot > longint'(DATA_MAX)) begin
            res.quotient = DATA_MAX;
            res.overflow = 1'b1;
        end else if (quot < longint'(DATA_MIN)) begin
            res.quotient = DATA_MIN;
            res.overflow = 1'b1;
        end else begin
            res.quotient = DATA_WIDTH'(quot);
        end
    end
    return res;
endfunction

task automatic compare_result(
    input  string       name,
    input  div_result_t expected,
    input  div_result_t actual,
    output bit          ok
);
    string exp_text;
    string act_text;
    ok = 1'b1;
    exp_text = $sformatf("q=%0d r=%0d ovf=%0b dbz=%0b", expected.quotient,
                         expected.remainder, expected.overflow, expected.div_by_zero);
    act_text = $sformatf("q=%0d r=%0d ovf=%0b dbz=%0b", actual.quotient,
                         actual.remainder, actual.overflow, actual.div_by_zero);
    if (actual !== expected) begin
        ok = 1'b0;
        $display("Error %s: expected %s, actual %s", name, exp_text, act_text);
    end else begin
        $display("%s: ok %s", name, act_text);
    end
endtask

`endif

//--- dv/fixed_point_divider_tb.sv
`timescale 1ns/1ns

module fixed_point_divider_tb
    import qdiv_pkg::*;
();

    localparam int CLOCK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_DIRECTED = 15;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_ZERO = 4;
    localparam int NUM_IGNORE = 2;
    localparam int NUM_REQUESTS = NUM_DIRECTED + NUM_RANDOM + NUM_ZERO + NUM_IGNORE;
    localparam longint WATCHDOG_TIME =
        longint'(NUM_REQUESTS) * (DIV_LATENCY + 4) * CLOCK_PERIOD * 2;

    logic         clock;
    logic         reset;
    div_request_t request;
    logic         valid_in;
    div_result_t  result;
    logic         valid_out;
    logic         busy;

    div_result_t  expect_q[$];  // one entry per accepted request
    string        name_q[$];
    div_result_t  expected;
    string        check_name;
    bit           check_ok;
    int           pass_count;
    int           fail_count;
    int           error_count;

    `include "div_ref_model.svh"

    fixed_point_divider dut_i (
        .clock     (clock),
        .reset     (reset),
        .request   (request),
        .valid_in  (valid_in),
        .result    (result),
        .valid_out (valid_out),
        .busy      (busy)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic logic signed [DATA_WIDTH-1:0] random_value(input int mode);
        logic signed [DATA_WIDTH-1:0] value;
        case (mode)
            0: value = $urandom;                   // full range
            1: value = $urandom_range(255, 1);     // small divisors push the quotient over
            default: value = $urandom_range(1 << 20, 0);
        endcase
        if (mode != 0 && $urandom_range(1, 0) == 1) begin
            value = -value;
        end
        return value;
    endfunction

    task automatic run_request(
        input string        name,
        input div_request_t req,
        input int           intrude_at,  // 0 means no second valid_in
        input div_request_t intruder
    );
        int cycles;
        cycles = 0;
        while (busy) begin
            @(negedge clock);
        end
        expect_q.push_back(ref_divide(req));
        name_q.push_back(name);
        request = req;
        valid_in = 1'b1;
        do begin
            @(negedge clock);
            cycles++;
            valid_in = 1'b0;
            if (cycles == intrude_at) begin
                request = intruder;
                valid_in = 1'b1;
            end
        end while (!valid_out && cycles < 2 * DIV_LATENCY);
        if (!valid_out) begin
            $display("%s: no valid_out within %0d cycles", name, cycles);
            error_count++;
        end else begin
            // the first falling edge already follows the accepting rising edge
            if (cycles - 1 != DIV_LATENCY) begin
                $display("Error %s latency: expected %0d cycles, actual %0d cycles",
                         name, DIV_LATENCY, cycles - 1);
                error_count++;
            end
            if (busy) begin
                $display("%s: busy is still high while valid_out is high", name);
                error_count++;
            end
        end
        @(negedge clock);
        if (valid_out) begin
            $display("%s: valid_out stayed high for more than one cycle", name);
            error_count++;
        end
    endtask

    task automatic run_division(
        input string                        name,
        input logic signed [DATA_WIDTH-1:0] dividend,
        input logic signed [DATA_WIDTH-1:0] divisor
    );
        div_request_t req;
        req.dividend = dividend;
        req.divisor = divisor;
        run_request(name, req, 0, '0);
    endtask

    ////////////////////////////////////////
    // result checker
    ////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && valid_out) begin
            if (expect_q.size() == 0) begin
                $display("valid_out came with no request outstanding");
                error_count++;
            end else begin
                expected = expect_q.pop_front();
                check_name = name_q.pop_front();
                compare_result(check_name, expected, result, check_ok);
                if (check_ok) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        div_request_t req;
        div_request_t intruder;
        int           errors_before;
        clock = 1'b0;
        reset = 1'b1;
        request = '0;
        valid_in = 1'b0;
        pass_count = 0;
        fail_count = 0;
        error_count = 0;
        void'($urandom(8429));

        // outputs stay quiet through reset and until the first request
        errors_before = error_count;
        for (int i = 0; i < RESET_CYCLES + 10; i++) begin
            @(negedge clock);
            if (busy || valid_out) begin
                $display("busy or valid_out is high at cycle %0d before any request", i);
                error_count++;
            end
            if (i == RESET_CYCLES - 1) begin
                reset = 1'b0;
            end
        end
        if (error_count == errors_before) begin
            $display("reset_idle: ok");
        end

        run_division("pos_by_pos", 1536, 512);  // 1.5 / 0.5
        run_division("neg_by_pos", -1536, 512);
        run_division("pos_by_neg", 1536, -512);
        run_division("neg_by_neg", -1536, -512);
        run_division("m7_by_2", -7168, 2048);
        run_division("7_by_m2", 7168, -2048);
        run_division("1_by_3", 1024, 3072);
        run_division("m10_by_3", -10240, 3072);
        run_division("raw_5_by_7", 5, 7);
        run_division("max_by_max", DATA_MAX, DATA_MAX);
        run_division("min_by_min", DATA_MIN, DATA_MIN);
        run_division("min_by_m1", DATA_MIN, -1);  // overflow to max
        run_division("max_by_1", DATA_MAX, 1);
        run_division("min_by_1", DATA_MIN, 1);    // overflow to min
        run_division("1_by_max", 1024, DATA_MAX);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            run_division($sformatf("random_%0d", i), random_value(i % 3),
                         random_value((i / 3) % 3));
        end

        run_division("zero_pos", 5120, 0);
        run_division("zero_neg", -5120, 0);
        run_division("zero_zero", 0, 0);
        run_division("zero_min", DATA_MIN, 0);

        req.dividend = 9216;  // 9 / 3
        req.divisor = 3072;
        intruder.dividend = -1024;
        intruder.divisor = 512;
        run_request("ignore_start_gap", req, 1, intruder);
        req.dividend = 20480;  // 20 / 3, signs differ from the intruder
        req.divisor = 3072;
        run_request("ignore_mid_run", req, 20, intruder);
        errors_before = error_count;
        repeat (2 * DIV_LATENCY) @(negedge clock);
        if (error_count == errors_before) begin
            $display("ignore_quiet: no extra valid_out");
        end

        $display("tests passed: %0d, tests failed: %0d, protocol errors: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0 && pass_count == NUM_REQUESTS) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+dv
src/qdiv_pkg.sv
src/div_operand_prep.sv
src/nonrestoring_divider.sv
src/div_result_format.sv
src/fixed_point_divider.sv
dv/fixed_point_divider_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fixed point divider testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module fixed_point_divider_tb \
    -Mdir "$BUILD_DIR" -o sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/sim" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG_FILE"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG_FILE"; then
    echo "no result line found in $LOG_FILE"
    exit 1
fi
exit 0
